//--- source/decode_consts.svh
// shared constants for the decode stage
// major opcodes, funct7 and funct12 values
// configuration register offsets and counter width
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define INSTR_W 32                   // instruction word width

// major opcodes, low two bits always 11 for 32-bit words
`define OPC_LOAD   7'b000_0011
`define OPC_STORE  7'b010_0011
`define OPC_BRANCH 7'b110_0011
`define OPC_JALR   7'b110_0111
`define OPC_JAL    7'b110_1111
`define OPC_OPIMM  7'b001_0011
`define OPC_OP     7'b011_0011
`define OPC_LUI    7'b011_0111
`define OPC_AUIPC  7'b001_0111
`define OPC_FENCE  7'b000_1111
`define OPC_SYSTEM 7'b111_0011

`define F7_BASE    7'b000_0000       // add, srl and the rest
`define F7_ALT     7'b010_0000       // sub, sra

`define SYS_ECALL  12'h000
`define SYS_EBREAK 12'h001
`define SYS_MRET   12'h302
`define SYS_DRET   12'h7b2
`define SYS_WFI    12'h105

`define CFG_ADDR_PRIV   8'h04
`define CFG_ADDR_DBG    8'h08
`define CFG_ADDR_ILLCNT 8'h0c
`define ILLCNT_W 16                  // saturating illegal counter

`endif

//--- source/apb_pkg.sv
// apb request and response structs for the configuration port
package apb_pkg;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;            // byte offset
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic        pready;
      logic        pslverr;          // unmapped offset
      logic [31:0] prdata;
   } apb_rsp_t;

endpackage

//--- source/rv_decode_pkg.sv
// instruction decode types
// operator and mux-select enums, privilege level
// configuration struct and decoder control struct with its illegal constant
package rv_decode_pkg;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU, ALU_SLL,
      ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
   } alu_op_e;

   typedef enum logic [1:0] {OP_A_REGA, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
   typedef enum logic       {OP_B_REGB, OP_B_IMM} op_b_sel_e;
   typedef enum logic [1:0] {OP_C_NONE, OP_C_REGB, OP_C_BCH} op_c_sel_e;
   typedef enum logic       {IMMA_ZERO, IMMA_Z} imm_a_sel_e;
   typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
   typedef enum logic [1:0] {CT_NONE, CT_JAL, CT_JALR, CT_BCH} ctrl_xfer_e;
   typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

   typedef enum logic [1:0] {
      PRIV_LVL_U = 2'b00,
      PRIV_LVL_M = 2'b11
   } priv_lvl_e;

   // steers mret, dret and wfi
   typedef struct packed {
      priv_lvl_e priv_lvl;
      logic      debug_mode;
      logic      mstatus_tw;
   } decode_cfg_t;

   typedef struct packed {
      logic       alu_en;            // unit enables
      logic       lsu_en;
      logic       csr_en;
      logic       sys_en;
      logic       alu_jmp;
      logic       alu_jmpr;          // jump target from rs1
      logic       alu_bch;
      op_a_sel_e  alu_op_a_mux_sel;
      op_b_sel_e  alu_op_b_mux_sel;
      op_c_sel_e  op_c_mux_sel;
      imm_a_sel_e imm_a_mux_sel;
      imm_b_sel_e imm_b_mux_sel;
      alu_op_e    alu_operator;
      logic       rf_we;
      logic [1:0] rf_re;             // [0] rs1, [1] rs2
      logic       lsu_we;
      logic       lsu_sext;
      logic [1:0] lsu_size;          // 00 byte, 01 half, 10 word
      ctrl_xfer_e ctrl_xfer;
      csr_op_e    csr_op;
      logic       sys_ecall;
      logic       sys_ebrk;
      logic       sys_mret;
      logic       sys_dret;
      logic       sys_wfi;
      logic       sys_fencei;
      logic       illegal;           // kept as lsb
   } decoder_ctrl_t;

   localparam int unsigned DECODER_CTRL_W = $bits(decoder_ctrl_t);
   // only the illegal bit set
   localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = decoder_ctrl_t'(DECODER_CTRL_W'(1));

endpackage

//--- source/ctrl_xfer_decoder.sv
// control transfer decode
// jal, jalr and the six branch compares
`include "decode_consts.svh"

module ctrl_xfer_decoder (
   input  logic [`INSTR_W-1:0]          instr_i,
   output rv_decode_pkg::decoder_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   always_comb begin
      ctrl_o         = DECODER_CTRL_ILLEGAL;
      ctrl_o.illegal = 1'b0;
      ctrl_o.alu_en  = 1'b1;

      if (instr_i[2]) begin                          // jal / jalr, alu builds link address
         ctrl_o.alu_jmp          = 1'b1;
         ctrl_o.alu_op_a_mux_sel = OP_A_CURRPC;
         ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
         ctrl_o.imm_b_mux_sel    = IMMB_PCINCR;     // pc + 4
         ctrl_o.alu_operator     = ALU_ADD;
         ctrl_o.rf_we            = 1'b1;            // link register
         ctrl_o.ctrl_xfer        = CT_JAL;
         if (!instr_i[3]) begin                     // jalr
            ctrl_o.alu_jmpr  = 1'b1;
            ctrl_o.rf_re[0]  = 1'b1;                // target from rs1
            ctrl_o.ctrl_xfer = CT_JALR;
            if (instr_i[14:12] != 3'b000) ctrl_o = DECODER_CTRL_ILLEGAL;
         end
      end else begin                                 // conditional branch
         ctrl_o.alu_bch          = 1'b1;
         ctrl_o.alu_op_a_mux_sel = OP_A_REGA;
         ctrl_o.alu_op_b_mux_sel = OP_B_REGB;
         ctrl_o.op_c_mux_sel     = OP_C_BCH;        // branch offset
         ctrl_o.rf_re            = 2'b11;
         ctrl_o.ctrl_xfer        = CT_BCH;
         case (instr_i[14:12])
            3'b000:  ctrl_o.alu_operator = ALU_EQ;
            3'b001:  ctrl_o.alu_operator = ALU_NE;
            3'b100:  ctrl_o.alu_operator = ALU_LT;
            3'b101:  ctrl_o.alu_operator = ALU_GE;
            3'b110:  ctrl_o.alu_operator = ALU_LTU;
            3'b111:  ctrl_o.alu_operator = ALU_GEU;
            default: ctrl_o = DECODER_CTRL_ILLEGAL; // 010, 011 reserved
         endcase
      end
   end

endmodule

//--- source/ldst_decoder.sv
// load and store decode
// access size, sign extension and reserved encodings
`include "decode_consts.svh"

module ldst_decoder (
   input  logic [`INSTR_W-1:0]          instr_i,
   output rv_decode_pkg::decoder_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   always_comb begin
      ctrl_o                  = DECODER_CTRL_ILLEGAL;
      ctrl_o.illegal          = 1'b0;
      ctrl_o.lsu_en           = 1'b1;
      ctrl_o.rf_re[0]         = 1'b1;               // base address
      ctrl_o.alu_op_a_mux_sel = OP_A_REGA;
      ctrl_o.alu_op_b_mux_sel = OP_B_IMM;           // offset
      ctrl_o.lsu_size         = instr_i[13:12];

      if (instr_i[5]) begin                          // store
         ctrl_o.lsu_we        = 1'b1;
         ctrl_o.rf_re[1]      = 1'b1;
         ctrl_o.op_c_mux_sel  = OP_C_REGB;          // write data
         ctrl_o.imm_b_mux_sel = IMMB_S;
         if (instr_i[14] || (instr_i[13:12] == 2'b11)) ctrl_o = DECODER_CTRL_ILLEGAL;
      end else begin                                 // load
         ctrl_o.rf_we         = 1'b1;
         ctrl_o.imm_b_mux_sel = IMMB_I;
         ctrl_o.lsu_sext      = !instr_i[14];       // lbu/lhu zero extend
         // 011 is rv64 ld, 110/111 reserved
         if ((instr_i[14:12] == 3'b011) || (instr_i[14:13] == 2'b11)) begin
            ctrl_o = DECODER_CTRL_ILLEGAL;
         end
      end
   end

endmodule

//--- source/alu_decoder.sv
// integer alu decode
// lui, auipc, op-imm and op into operator and operand selects
`include "decode_consts.svh"

module alu_decoder (
   input  logic [`INSTR_W-1:0]          instr_i,
   output rv_decode_pkg::decoder_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   logic [6:0] funct7;
   logic [2:0] funct3;

   assign funct7 = instr_i[31:25];
   assign funct3 = instr_i[14:12];

   always_comb begin
      ctrl_o              = DECODER_CTRL_ILLEGAL;
      ctrl_o.illegal      = 1'b0;
      ctrl_o.alu_en       = 1'b1;
      ctrl_o.rf_we        = 1'b1;
      ctrl_o.alu_operator = ALU_ADD;

      if (instr_i[2]) begin                          // upper immediate forms
         ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
         ctrl_o.imm_b_mux_sel    = IMMB_U;
         if (instr_i[5]) begin                      // lui, 0 + imm
            ctrl_o.alu_op_a_mux_sel = OP_A_IMM;
            ctrl_o.imm_a_mux_sel    = IMMA_ZERO;
         end else begin                             // auipc, pc + imm
            ctrl_o.alu_op_a_mux_sel = OP_A_CURRPC;
         end
      end else if (!instr_i[5]) begin                // op-imm
         ctrl_o.alu_op_a_mux_sel = OP_A_REGA;
         ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
         ctrl_o.imm_b_mux_sel    = IMMB_I;
         ctrl_o.rf_re[0]         = 1'b1;
         case (funct3)
            3'b000: ctrl_o.alu_operator = ALU_ADD;
            3'b010: ctrl_o.alu_operator = ALU_SLT;
            3'b011: ctrl_o.alu_operator = ALU_SLTU;
            3'b100: ctrl_o.alu_operator = ALU_XOR;
            3'b110: ctrl_o.alu_operator = ALU_OR;
            3'b111: ctrl_o.alu_operator = ALU_AND;
            3'b001: begin                           // slli, shamt only
               ctrl_o.alu_operator = ALU_SLL;
               if (funct7 != `F7_BASE) ctrl_o = DECODER_CTRL_ILLEGAL;
            end
            default: begin                          // srli / srai
               if (funct7 == `F7_BASE)     ctrl_o.alu_operator = ALU_SRL;
               else if (funct7 == `F7_ALT) ctrl_o.alu_operator = ALU_SRA;
               else                        ctrl_o = DECODER_CTRL_ILLEGAL;
            end
         endcase
      end else begin                                 // register-register op
         ctrl_o.alu_op_a_mux_sel = OP_A_REGA;
         ctrl_o.alu_op_b_mux_sel = OP_B_REGB;
         ctrl_o.rf_re            = 2'b11;
         case ({funct7, funct3})
            {`F7_BASE, 3'b000}: ctrl_o.alu_operator = ALU_ADD;
            {`F7_ALT,  3'b000}: ctrl_o.alu_operator = ALU_SUB;
            {`F7_BASE, 3'b001}: ctrl_o.alu_operator = ALU_SLL;
            {`F7_BASE, 3'b010}: ctrl_o.alu_operator = ALU_SLT;
            {`F7_BASE, 3'b011}: ctrl_o.alu_operator = ALU_SLTU;
            {`F7_BASE, 3'b100}: ctrl_o.alu_operator = ALU_XOR;
            {`F7_BASE, 3'b101}: ctrl_o.alu_operator = ALU_SRL;
            {`F7_ALT,  3'b101}: ctrl_o.alu_operator = ALU_SRA;
            {`F7_BASE, 3'b110}: ctrl_o.alu_operator = ALU_OR;
            {`F7_BASE, 3'b111}: ctrl_o.alu_operator = ALU_AND;
            default:            ctrl_o = DECODER_CTRL_ILLEGAL; // m-ext and others
         endcase
      end
   end

endmodule

//--- source/system_decoder.sv
// system decode
// fence / fence.i, ecall, ebreak, mret, dret, wfi and the csr instructions
// privileged forms checked against the current configuration
`include "decode_consts.svh"

module system_decoder (
   input  logic [`INSTR_W-1:0]          instr_i,
   input  rv_decode_pkg::decode_cfg_t   cfg_i,
   output rv_decode_pkg::decoder_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   logic rs1_rd_zero;

   assign rs1_rd_zero = ({instr_i[19:15], instr_i[11:7]} == 10'b0);

   always_comb begin
      ctrl_o         = DECODER_CTRL_ILLEGAL;
      ctrl_o.illegal = 1'b0;

      if (!instr_i[4]) begin                         // misc-mem
         ctrl_o.sys_en = 1'b1;
         // plain fence handled as fence.i, flushes the pipe either way
         if (instr_i[14:13] == 2'b00) ctrl_o.sys_fencei = 1'b1;
         else                         ctrl_o = DECODER_CTRL_ILLEGAL;
      end else if (instr_i[14:12] == 3'b000) begin   // privileged, no csr
         ctrl_o.sys_en = 1'b1;
         case (instr_i[31:20])
            `SYS_ECALL:  ctrl_o.sys_ecall = 1'b1;
            `SYS_EBREAK: ctrl_o.sys_ebrk  = 1'b1;
            `SYS_MRET: begin
               if (cfg_i.priv_lvl != PRIV_LVL_M) ctrl_o = DECODER_CTRL_ILLEGAL;
               else                              ctrl_o.sys_mret = 1'b1;
            end
            `SYS_DRET: begin                        // only legal in debug mode
               if (cfg_i.debug_mode) ctrl_o.sys_dret = 1'b1;
               else                  ctrl_o = DECODER_CTRL_ILLEGAL;
            end
            `SYS_WFI: begin                         // user wfi traps when tw set
               if ((cfg_i.priv_lvl == PRIV_LVL_U) && cfg_i.mstatus_tw) begin
                  ctrl_o = DECODER_CTRL_ILLEGAL;
               end else begin
                  ctrl_o.sys_wfi = 1'b1;
               end
            end
            default: ctrl_o = DECODER_CTRL_ILLEGAL;
         endcase
         if (!rs1_rd_zero) ctrl_o = DECODER_CTRL_ILLEGAL;
      end else begin                                 // csr access
         ctrl_o.csr_en           = 1'b1;
         ctrl_o.rf_we            = 1'b1;
         ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
         ctrl_o.imm_a_mux_sel    = IMMA_Z;          // zero-extended uimm
         ctrl_o.imm_b_mux_sel    = IMMB_I;          // csr address
         if (instr_i[14]) begin
            ctrl_o.alu_op_a_mux_sel = OP_A_IMM;     // rs1 field is the immediate
         end else begin
            ctrl_o.alu_op_a_mux_sel = OP_A_REGA;
            ctrl_o.rf_re[0]         = 1'b1;
         end
         // set/clear with a zero source only reads
         case (instr_i[13:12])
            2'b01:   ctrl_o.csr_op = CSR_OP_WRITE;
            2'b10:   ctrl_o.csr_op = (instr_i[19:15] == 5'b0) ? CSR_OP_READ : CSR_OP_SET;
            2'b11:   ctrl_o.csr_op = (instr_i[19:15] == 5'b0) ? CSR_OP_READ : CSR_OP_CLEAR;
            default: ctrl_o = DECODER_CTRL_ILLEGAL;
         endcase
      end
   end

endmodule

//--- source/decode_cfg_regs.sv
// apb configuration registers for the decode stage
// privilege level, debug mode and mstatus.tw
// saturating illegal-instruction counter, cleared by any write
`include "decode_consts.svh"

module decode_cfg_regs (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  apb_pkg::apb_req_t          apb_req_i,
   output apb_pkg::apb_rsp_t          apb_rsp_o,
   input  logic                       illegal_seen_i,
   output rv_decode_pkg::decode_cfg_t cfg_o
);
   import rv_decode_pkg::*;

   logic                 access;                   // apb access phase
   logic                 addr_hit;
   logic                 wr_en;
   logic [`ILLCNT_W-1:0] ill_cnt;

   assign access = apb_req_i.psel & apb_req_i.penable;
   assign wr_en  = access & apb_req_i.pwrite;

   //////////////////////////////
   // read mux and response
   always_comb begin
      addr_hit          = 1'b1;
      apb_rsp_o.prdata  = '0;
      case (apb_req_i.paddr)
         `CFG_ADDR_PRIV:   apb_rsp_o.prdata = 32'(cfg_o.priv_lvl);
         `CFG_ADDR_DBG:    apb_rsp_o.prdata = {30'b0, cfg_o.mstatus_tw, cfg_o.debug_mode};
         `CFG_ADDR_ILLCNT: apb_rsp_o.prdata = 32'(ill_cnt);
         default:          addr_hit = 1'b0;
      endcase
      apb_rsp_o.pready  = access;                  // zero wait states
      apb_rsp_o.pslverr = access & ~addr_hit;
   end

   //////////////////////////////
   // configuration, live for the next word
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         cfg_o <= '{priv_lvl: PRIV_LVL_M, debug_mode: 1'b0, mstatus_tw: 1'b0};
      end else if (wr_en) begin
         case (apb_req_i.paddr)
            `CFG_ADDR_PRIV: begin                   // only U and M exist
               cfg_o.priv_lvl <= (apb_req_i.pwdata[1:0] == 2'b11) ? PRIV_LVL_M : PRIV_LVL_U;
            end
            `CFG_ADDR_DBG: begin
               cfg_o.debug_mode <= apb_req_i.pwdata[0];
               cfg_o.mstatus_tw <= apb_req_i.pwdata[1];
            end
            default: ;                              // illcnt below, others ignored
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ill_cnt <= '0;
      end else if (wr_en && (apb_req_i.paddr == `CFG_ADDR_ILLCNT)) begin
         ill_cnt <= '0;                             // clear wins over a count
      end else if (illegal_seen_i && !(&ill_cnt)) begin
         ill_cnt <= ill_cnt + 1'b1;                 // stick at max
      end
   end

   a_penable_needs_psel : assert property (@(posedge clk) disable iff (!rst_n_i)
      apb_req_i.penable |-> apb_req_i.psel);

endmodule

//--- source/id_decode_top.sv
// registered rv32i decode stage
// opcode selects one sub-decoder, the result is registered with its valid
// compressed and unknown words decode as illegal
`include "decode_consts.svh"

module id_decode_top (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         instr_valid_i,
   input  logic [`INSTR_W-1:0]          instr_i,
   output logic                         ctrl_valid_o,
   output rv_decode_pkg::decoder_ctrl_t ctrl_o,
   input  apb_pkg::apb_req_t            apb_req_i,
   output apb_pkg::apb_rsp_t            apb_rsp_o
);
   import rv_decode_pkg::*;

   decoder_ctrl_t xfer_ctrl, ldst_ctrl, alu_ctrl, sys_ctrl;
   decoder_ctrl_t dec_ctrl;                        // selected, pre-register
   decode_cfg_t   cfg;

   ctrl_xfer_decoder i_ctrl_xfer_decoder (.instr_i(instr_i), .ctrl_o(xfer_ctrl));
   ldst_decoder      i_ldst_decoder      (.instr_i(instr_i), .ctrl_o(ldst_ctrl));
   alu_decoder       i_alu_decoder       (.instr_i(instr_i), .ctrl_o(alu_ctrl));
   system_decoder    i_system_decoder    (.instr_i(instr_i), .cfg_i(cfg), .ctrl_o(sys_ctrl));

   decode_cfg_regs i_decode_cfg_regs (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .apb_req_i      (apb_req_i),
      .apb_rsp_o      (apb_rsp_o),
      .illegal_seen_i (ctrl_valid_o & ctrl_o.illegal), // counted on the output cycle
      .cfg_o          (cfg)
   );

   // full 7-bit match, so low bits other than 11 fall into default
   always_comb begin
      case (instr_i[6:0])
         `OPC_JAL, `OPC_JALR, `OPC_BRANCH:           dec_ctrl = xfer_ctrl;
         `OPC_LOAD, `OPC_STORE:                      dec_ctrl = ldst_ctrl;
         `OPC_LUI, `OPC_AUIPC, `OPC_OPIMM, `OPC_OP:  dec_ctrl = alu_ctrl;
         `OPC_FENCE, `OPC_SYSTEM:                    dec_ctrl = sys_ctrl;
         default:                                    dec_ctrl = DECODER_CTRL_ILLEGAL;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ctrl_valid_o <= 1'b0;
         ctrl_o       <= '0;
      end else begin
         ctrl_valid_o <= instr_valid_i;           // one cycle latency, no stall
         if (instr_valid_i) ctrl_o <= dec_ctrl;
      end
   end

   a_illegal_no_enable : assert property (@(posedge clk) disable iff (!rst_n_i)
      (ctrl_valid_o && ctrl_o.illegal)
         |-> !(ctrl_o.alu_en || ctrl_o.lsu_en || ctrl_o.csr_en || ctrl_o.sys_en));

endmodule

//--- tests/decode_checker.sv
// checker for the decode stage
// queued expectations for decoded words and apb reads
// words compared on the falling edge, apb reads in the access phase
`include "decode_consts.svh"

module decode_checker #(
   parameter int PERIOD = 4                        // one clock, the decode latency
) (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         ctrl_valid_i,
   input  rv_decode_pkg::decoder_ctrl_t ctrl_i,
   input  apb_pkg::apb_req_t            apb_req_i,
   input  apb_pkg::apb_rsp_t            apb_rsp_i,
   output int                           mismatch_o,
   output int                           fault_o
);
   import rv_decode_pkg::*;

   typedef struct packed {
      logic [63:0]         stamp;                  // time the word was driven
      logic [`INSTR_W-1:0] instr;
      decoder_ctrl_t       ctrl;                   // unlisted fields left zero
   } word_exp_t;

   word_exp_t   word_q[$];                         // in issue order
   logic [32:0] read_q[$];                         // {pslverr, prdata}
   int          word_mis = 0;
   int          word_flt = 0;
   int          read_mis = 0;
   int          read_flt = 0;

   assign mismatch_o = word_mis + read_mis;
   assign fault_o    = word_flt + read_flt;

   task automatic expect_word(input logic [`INSTR_W-1:0] instr, input decoder_ctrl_t ctrl);
      word_q.push_back({64'($time), instr, ctrl});
   endtask

   task automatic expect_read(input logic [31:0] data, input logic err);
      read_q.push_back({err, data});
   endtask

   function automatic int pending_count();
      return word_q.size() + read_q.size();
   endfunction

   // an illegal word carries the flag and nothing else
   function automatic logic fields_match(decoder_ctrl_t got, decoder_ctrl_t exp);
      decoder_ctrl_t bare;
      bare         = '0;
      bare.illegal = 1'b1;
      if (exp.illegal) return got === bare;
      return (got.alu_en === exp.alu_en) && (got.lsu_en === exp.lsu_en) &&
             (got.csr_en === exp.csr_en) && (got.sys_en === exp.sys_en) &&
             (got.alu_op_a_mux_sel === exp.alu_op_a_mux_sel) &&
             (got.alu_operator === exp.alu_operator) &&
             (got.ctrl_xfer === exp.ctrl_xfer) &&
             (got.lsu_size === exp.lsu_size) && (got.lsu_sext === exp.lsu_sext) &&
             (got.csr_op === exp.csr_op) && (got.illegal === 1'b0);
   endfunction

   //////////////////////////////
   // decoded words
   always @(negedge clk) begin : word_check
      word_exp_t e;
      if (rst_n_i && ctrl_valid_i) begin
         if (word_q.size() == 0) begin
            $display("decoded word at %0t with no word issued", $time);
            word_flt++;
         end else begin
            e = word_q.pop_front();
            if ($time - e.stamp != PERIOD) begin     // must be exactly one cycle
               $display("mismatch at %0t: word %h out %0d time units after issue, not %0d",
                        $time, e.instr, $time - e.stamp, PERIOD);
               word_mis++;
            end
            if (!fields_match(ctrl_i, e.ctrl)) begin
               $display("mismatch at %0t: word %h decoded to %h, expected %h",
                        $time, e.instr, ctrl_i, e.ctrl);
               word_mis++;
            end
         end
      end
   end

   //////////////////////////////
   // apb reads, request is stable since the falling edge
   always @(posedge clk) begin : read_check
      logic [32:0] r;
      if (rst_n_i && apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready
          && !apb_req_i.pwrite) begin
         if (read_q.size() == 0) begin
            $display("apb read of %h at %0t with no expected value", apb_req_i.paddr, $time);
            read_flt++;
         end else begin
            r = read_q.pop_front();
            if (apb_rsp_i.pslverr !== r[32]) begin
               $display("mismatch at %0t: read of %h pslverr %b, expected %b",
                        $time, apb_req_i.paddr, apb_rsp_i.pslverr, r[32]);
               read_mis++;
            end else if (!r[32] && (apb_rsp_i.prdata !== r[31:0])) begin
               $display("mismatch at %0t: read of %h returned %h, expected %h",
                        $time, apb_req_i.paddr, apb_rsp_i.prdata, r[31:0]);
               read_mis++;
            end
         end
      end
   end

endmodule

//--- tests/tb_decode.sv
// testbench top for the decode stage
// clock and reset, apb transfers and instruction words from the data file
// expectations go to the checker in issue order
`include "decode_consts.svh"

module tb_decode;
   import rv_decode_pkg::*;
   import apb_pkg::*;

   localparam int TIMEOUT_CYC = 20;                // cycles allowed for any one wait

   logic                clk;
   logic                rst_n;
   logic                instr_valid;
   logic [`INSTR_W-1:0] instr;
   logic                ctrl_valid;
   decoder_ctrl_t       ctrl;
   apb_req_t            apb_req;
   apb_rsp_t            apb_rsp;
   int                  mismatch_cnt;
   int                  fault_cnt;                 // from the checker
   int                  tb_fault;                  // bad data file lines
   int                  timeout_cnt;

   always #2 clk = ~clk;

   id_decode_top i_id_decode_top (
      .clk           (clk),
      .rst_n_i       (rst_n),
      .instr_valid_i (instr_valid),
      .instr_i       (instr),
      .ctrl_valid_o  (ctrl_valid),
      .ctrl_o        (ctrl),
      .apb_req_i     (apb_req),
      .apb_rsp_o     (apb_rsp)
   );

   decode_checker #(.PERIOD(4)) i_decode_checker (
      .clk          (clk),
      .rst_n_i      (rst_n),
      .ctrl_valid_i (ctrl_valid),
      .ctrl_i       (ctrl),
      .apb_req_i    (apb_req),
      .apb_rsp_i    (apb_rsp),
      .mismatch_o   (mismatch_cnt),
      .fault_o      (fault_cnt)
   );

   // stop issuing, then wait until every expectation is checked
   task automatic quiet_inputs();
      int n;
      @(negedge clk);
      instr_valid = 1'b0;
      apb_req     = '0;
      n = 0;
      while ((i_decode_checker.pending_count() != 0) && (n < TIMEOUT_CYC)) begin
         @(posedge clk);
         n++;
      end
      if (i_decode_checker.pending_count() != 0) begin
         $display("timeout at %0t: decoded words or apb reads still outstanding", $time);
         timeout_cnt++;
      end
   endtask

   // setup then access phase, returns at the completing edge
   task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] data);
      int n;
      @(negedge clk);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
      @(negedge clk);
      apb_req.penable = 1'b1;
      @(posedge clk);
      n = 0;
      while (!apb_rsp.pready && (n < TIMEOUT_CYC)) begin
         @(posedge clk);
         n++;
      end
      if (!apb_rsp.pready) begin
         $display("timeout at %0t: no pready for offset %h", $time, addr);
         timeout_cnt++;
      end
   endtask

   task automatic run_line(input string line);
      int            n;
      logic [31:0]   w;
      logic [31:0]   data;
      logic [7:0]    addr;
      logic          ill;
      logic          sext;
      logic          err;
      logic [3:0]    en;                           // alu, lsu, csr, sys
      logic [4:0]    op;
      logic [1:0]    opa;
      logic [1:0]    xfer;
      logic [1:0]    size;
      logic [1:0]    csr;
      decoder_ctrl_t exp;
      n = 0;
      case (line.getc(0))
         "I": begin
            n = $sscanf(line, "I %h %h %b %h %h %h %h %h %h",
                        w, ill, en, opa, op, xfer, size, sext, csr);
            exp = '0;
            exp.illegal = ill;
            {exp.alu_en, exp.lsu_en, exp.csr_en, exp.sys_en} = en;
            exp.alu_op_a_mux_sel = op_a_sel_e'(opa);
            exp.alu_operator     = alu_op_e'(op);
            exp.ctrl_xfer        = ctrl_xfer_e'(xfer);
            exp.lsu_size         = size;
            exp.lsu_sext         = sext;
            exp.csr_op           = csr_op_e'(csr);
            @(negedge clk);                        // back to back, one per cycle
            apb_req     = '0;
            instr_valid = 1'b1;
            instr       = w;
            i_decode_checker.expect_word(w, exp);
            n = (n == 9) ? 1 : 0;
         end
         "W": begin
            n = $sscanf(line, "W %h %h", addr, data);
            quiet_inputs();
            apb_xfer(1'b1, addr, data);
            n = (n == 2) ? 1 : 0;
         end
         "R": begin
            n = $sscanf(line, "R %h %h %h", addr, data, err);
            quiet_inputs();
            i_decode_checker.expect_read(data, err);
            apb_xfer(1'b0, addr, 32'h0);
            n = (n == 3) ? 1 : 0;
         end
         default: n = 0;
      endcase
      if (n == 0) begin
         $display("data file line not understood: %s", line);
         tb_fault++;
      end
   endtask

   initial begin : stimulus
      string line;
      int    fd;
      int    code;
      clk         = 1'b0;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      apb_req     = '0;
      tb_fault    = 0;
      timeout_cnt = 0;
      repeat (2) @(posedge clk);                   // reset for two cycles
      @(negedge clk);
      rst_n = 1'b1;
      fd = $fopen("tests/decode_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open tests/decode_tests.txt");
         tb_fault++;
      end else begin
         while (!$feof(fd) && (timeout_cnt == 0)) begin
            code = $fgets(line, fd);
            if ((code > 0) && (line.len() > 1) && (line.getc(0) != "#")) run_line(line);
         end
         $fclose(fd);
      end
      quiet_inputs();
      $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
               mismatch_cnt, fault_cnt + tb_fault, timeout_cnt);
      if ((mismatch_cnt + fault_cnt + tb_fault + timeout_cnt) == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+source
source/apb_pkg.sv
source/rv_decode_pkg.sv
source/ctrl_xfer_decoder.sv
source/ldst_decoder.sv
source/alu_decoder.sv
source/system_decoder.sv
source/decode_cfg_regs.sv
source/id_decode_top.sv
tests/decode_checker.sv
tests/tb_decode.sv

//--- tests/decode_tests.txt
# I instr illegal en(alu lsu csr sys, binary) op_a alu_op ctrl_xfer lsu_size lsu_sext csr_op
# W offset data, R offset data pslverr; all other fields hex
I 00500093 0 1000 0 0 0 0 0 0   addi
I 002081b3 0 1000 0 0 0 0 0 0   add
I 40208233 0 1000 0 1 0 0 0 0   sub
I 4020d2b3 0 1000 0 9 0 0 0 0   sra
I 4030d313 0 1000 0 9 0 0 0 0   srai
I 0020b3b3 0 1000 0 6 0 0 0 0   sltu
I 12345437 0 1000 2 0 0 0 0 0   lui
I 00001497 0 1000 1 0 0 0 0 0   auipc
I 0040a503 0 0100 0 0 0 2 1 0   lw
I 0000c583 0 0100 0 0 0 0 0 0   lbu
I 00209603 0 0100 0 0 0 1 1 0   lh
I 0020a423 0 0100 0 0 0 2 0 0   sw
I 00208023 0 0100 0 0 0 0 0 0   sb
I 010000ef 0 1000 1 0 1 0 0 0   jal
I 00008067 0 1000 1 0 2 0 0 0   jalr
I 00208463 0 1000 0 a 3 0 0 0   beq
I 0020f463 0 1000 0 f 3 0 0 0   bgeu
I 0020c463 0 1000 0 c 3 0 0 0   blt
I 0ff0000f 0 0001 0 0 0 0 0 0   fence
I 0000100f 0 0001 0 0 0 0 0 0   fence.i
I 00000073 0 0001 0 0 0 0 0 0   ecall
I 00100073 0 0001 0 0 0 0 0 0   ebreak
I 00000001 1 0000 0 0 0 0 0 0   compressed
I 0000000b 1 0000 0 0 0 0 0 0   unknown opcode
I 0020a463 1 0000 0 0 0 0 0 0   branch funct3 2
I 0000e583 1 0000 0 0 0 0 0 0   load funct3 6
I 0020b023 1 0000 0 0 0 0 0 0   store size 11
I 40309313 1 0000 0 0 0 0 0 0   slli with funct7 0100000
I 022081b3 1 0000 0 0 0 0 0 0   mul
I 0000200f 1 0000 0 0 0 0 0 0   fence funct3 2
I 30200073 0 0001 0 0 0 0 0 0   mret in M
I 7b200073 1 0000 0 0 0 0 0 0   dret, debug off
W 08 1
I 7b200073 0 0001 0 0 0 0 0 0   dret, debug on
W 04 0
I 30200073 1 0000 0 0 0 0 0 0   mret in U
I 10500073 0 0001 0 0 0 0 0 0   wfi in U, tw off
W 08 3
I 10500073 1 0000 0 0 0 0 0 0   wfi in U, tw on
R 04 0 0
R 08 3 0
W 04 3
I 30200073 0 0001 0 0 0 0 0 0   mret in M
I 10500073 0 0001 0 0 0 0 0 0   wfi in M, tw on
R 10 0 1
I 300022f3 0 0010 0 0 0 0 0 0   csrrs rs1 zero
I 3000a2f3 0 0010 0 0 0 0 0 2   csrrs
I 300032f3 0 0010 0 0 0 0 0 0   csrrc rs1 zero
I 3000b2f3 0 0010 0 0 0 0 0 3   csrrc
I 300092f3 0 0010 0 0 0 0 0 1   csrrw
I 3002d2f3 0 0010 2 0 0 0 0 1   csrrwi
I 300062f3 0 0010 2 0 0 0 0 0   csrrsi uimm zero
I 300272f3 0 0010 2 0 0 0 0 3   csrrci
# eleven illegal words above
R 0c b 0
W 0c 0
R 0c 0 0
